/* sim.f */
hdl/snes_cart_pkg.sv
hdl/rom_header_detect.sv
hdl/cheat_code_loader.sv
hdl/bsram_access.sv
hdl/backup_sequencer.sv
hdl/snes_cart_top.sv
tests/snes_cart_assertions.sv
tests/tb_snes_cart.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_snes_cart
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_snes_cart.sv */
`timescale 1ns/100ps

module tb_snes_cart;

	import snes_cart_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int BSRAM_BITS = 17;
	localparam int REQ_WAIT_LIMIT = 64;
	// Rough cycle budget per test with the two disk tests dominating
	localparam int TEST_CYCLES = 100 + 100 + 60 + 200 + 3400 + 3400;
	localparam int MARGIN_CYCLES = 1000;

	logic        clk_sys;
	logic        RESET;
	dl_bus_t     dl;
	cart_cfg_t   cfg;
	bsram_req_t  req;
	logic [7:0]  rdata;
	cart_info_t  cart_info;
	cheat_code_t code;
	logic        code_valid;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        sd_ack;
	logic [7:0]  sd_buff_addr;
	logic [15:0] sd_buff_dout;
	logic        sd_buff_wr;
	logic [15:0] sd_buff_din;
	logic        img_mounted;
	logic        img_readonly;
	logic [31:0] img_size;
	logic        osd_status;
	logic        bk_load_req;
	logic        bk_save_req;
	logic        bk_ena;
	logic        bk_pending;
	logic        bk_busy;
	logic        bk_loading;

	logic [31:0] lfsr;
	// Expected BSRAM contents by byte address
	logic [7:0]  model [2048];

	snes_cart_top #(
		.BSRAM_BITS (BSRAM_BITS)
	) i_snes_cart_top (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.cfg          (cfg),
		.req          (req),
		.rdata        (rdata),
		.cart_info    (cart_info),
		.code         (code),
		.code_valid   (code_valid),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_din  (sd_buff_din),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.osd_status   (osd_status),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ========================================
	// Helpers
	// ========================================
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t: %s got %0h expected %0h",
				$time, name, got, want));
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [15:0] take_bits(input int n);
		logic        fb;
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[14:0], fb};
		end
		return value;
	endfunction

	task automatic dl_begin(input logic [7:0] index);
		dl.active = 1'b1;
		dl.index = index;
		dl.addr = '0;
		dl.data = '0;
		dl.wr = 1'b0;
		next_cycle();
	endtask

	task automatic dl_strobe(input logic [24:0] addr, input logic [15:0] data);
		dl.addr = addr;
		dl.data = data;
		dl.wr = 1'b1;
		next_cycle();
		dl.wr = 1'b0;
	endtask

	task automatic dl_write(input logic [24:0] addr, input logic [15:0] data);
		dl_strobe(addr, data);
		next_cycle();
	endtask

	task automatic dl_finish();
		dl = '0;
		next_cycle();
	endtask

	task automatic console_write(input int addr, input logic [7:0] data);
		req.addr = 20'(addr);
		req.data = data;
		req.en = 1'b1;
		req.wr = 1'b1;
		next_cycle();
		req.en = 1'b0;
		req.wr = 1'b0;
	endtask

	// Read data is taken one clock after the request
	task automatic console_read(input int addr, output logic [7:0] data);
		req.addr = 20'(addr);
		req.en = 1'b1;
		req.wr = 1'b0;
		next_cycle();
		req.en = 1'b0;
		data = rdata;
	endtask

	task automatic wait_request(input logic load);
		int waited;
		waited = 0;
		while (!(sd_rd || sd_wr)) begin
			if (waited == REQ_WAIT_LIMIT)
				fail_run($sformatf("timeout waiting for a disk request, load=%0b", load));
			next_cycle();
			waited++;
		end
		check_value("bk_busy", 128'(bk_busy), 128'(1'b1));
		check_value("bk_loading", 128'(bk_loading), 128'(load));
		check_value("sd_rd", 128'(sd_rd), 128'(load));
		check_value("sd_wr", 128'(sd_wr), 128'(!load));
	endtask

	task automatic wait_idle(input logic load);
		int waited;
		waited = 0;
		while (bk_busy) begin
			check_value("bk_loading", 128'(bk_loading), 128'(load));
			if (waited == REQ_WAIT_LIMIT)
				fail_run("timeout waiting for bk_busy to fall");
			next_cycle();
			waited++;
		end
		check_value("bk_loading", 128'(bk_loading), 128'(1'b0));
	endtask

	// Host side of one save sector
	task automatic serve_save_sector(input int lba);
		int base;
		base = lba * 512;
		sd_ack = 1'b1;
		for (int k = 0; k < 256; k++) begin
			sd_buff_addr = 8'(k);
			next_cycle();
			if (k == 0)
				check_value("sd_wr", 128'(sd_wr), 128'(1'b0));
			check_value("sd_rd", 128'(sd_rd), 128'(1'b0));
			check_value("sd_buff_din", 128'(sd_buff_din),
				128'({model[base + 2 * k + 1], model[base + 2 * k]}));
		end
		sd_ack = 1'b0;
		next_cycle();
	endtask

	// Host side of one load sector
	task automatic serve_load_sector(input int lba);
		int base;
		logic [15:0] word;
		base = lba * 512;
		sd_ack = 1'b1;
		for (int k = 0; k < 256; k++) begin
			word = take_bits(16);
			model[base + 2 * k] = word[7:0];
			model[base + 2 * k + 1] = word[15:8];
			sd_buff_addr = 8'(k);
			sd_buff_dout = word;
			sd_buff_wr = 1'b1;
			next_cycle();
			if (k == 0)
				check_value("sd_rd", 128'(sd_rd), 128'(1'b0));
			check_value("bk_loading", 128'(bk_loading), 128'(1'b1));
		end
		sd_buff_wr = 1'b0;
		sd_ack = 1'b0;
		next_cycle();
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic auto_header_test();
		cfg.header_mode = 3'd0;
		cfg.region_sel = 2'd0;
		dl_begin(8'h00);
		dl_write(25'd0, 16'h353A);
		dl_write(25'd2, 16'h0100);
		dl_finish();
		next_cycle();
		// ROM size 10 is 1 MiB and RAM size 3 is 8 KiB
		check_value("rom_type", 128'(cart_info.rom_type), 128'(8'h35));
		check_value("rom_mask", 128'(cart_info.rom_mask), 128'(24'h0FFFFF));
		check_value("ram_mask", 128'(cart_info.ram_mask), 128'(24'h001FFF));
		check_value("pal", 128'(cart_info.pal), 128'(1'b1));
		// Forced region overrides the header bit
		cfg.region_sel = 2'd1;
		next_cycle();
		check_value("pal", 128'(cart_info.pal), 128'(1'b0));
		cfg.region_sel = 2'd2;
		next_cycle();
		check_value("pal", 128'(cart_info.pal), 128'(1'b1));
		cfg.region_sel = 2'd0;
		next_cycle();
		check_value("pal", 128'(cart_info.pal), 128'(1'b1));
	endtask

	task automatic forced_mode_test(input logic [2:0] mode, input logic [24:0] base,
			input logic [3:0] rom_size, input logic [3:0] ram_size,
			input logic [7:0] want_type, input logic [23:0] want_rom_mask,
			input logic [23:0] want_ram_mask);
		logic [24:0] size_addr;
		size_addr = base + 25'(HDR_SKIP);
		cfg.header_mode = mode;
		dl_begin(8'h00);
		dl_write(25'd0, 16'h77FF);
		dl_write(size_addr, {4'h0, rom_size, 8'h00});
		dl_write(size_addr + 25'd2, {12'h000, ram_size});
		dl_finish();
		next_cycle();
		check_value("rom_type", 128'(cart_info.rom_type), 128'(want_type));
		check_value("rom_mask", 128'(cart_info.rom_mask), 128'(want_rom_mask));
		check_value("ram_mask", 128'(cart_info.ram_mask), 128'(want_ram_mask));
		cfg.header_mode = 3'd0;
	endtask

	task automatic cheat_code_test();
		logic [15:0] half [8];
		for (int i = 0; i < 8; i++)
			half[i] = take_bits(16);
		dl_begin(CODE_INDEX);
		for (int i = 0; i < 7; i++) begin
			dl_strobe(25'(2 * i), half[i]);
			check_value("code_valid", 128'(code_valid), 128'(1'b0));
			next_cycle();
		end
		dl_strobe(25'd14, half[7]);
		check_value("code_valid", 128'(code_valid), 128'(1'b1));
		check_value("code.flags", 128'(code.flags), 128'({half[1], half[0]}));
		check_value("code.address", 128'(code.address), 128'({half[3], half[2]}));
		check_value("code.compare", 128'(code.compare), 128'({half[5], half[4]}));
		check_value("code.replace", 128'(code.replace), 128'({half[7], half[6]}));
		next_cycle();
		check_value("code_valid", 128'(code_valid), 128'(1'b0));
		dl_finish();
	endtask

	task automatic fill_console_test();
		logic [15:0] bits;
		logic [7:0]  byte_a;
		logic [7:0]  byte_b;
		logic [7:0]  got;
		cfg.sram_init = 2'd1;
		dl_begin(8'h00);
		for (int a = 'h40; a < 'h60; a++) begin
			bits = take_bits(16);
			dl_write(25'(a), bits);
		end
		dl_finish();
		cfg.sram_init = 2'd0;
		for (int a = 'h40; a < 'h60; a++) begin
			console_read(a, got);
			check_value("rdata", 128'(got), 128'(8'hFF));
		end
		bits = take_bits(8);
		byte_a = bits[7:0];
		bits = take_bits(8);
		byte_b = bits[7:0];
		console_write('h45, byte_a);
		console_write('h46, byte_b);
		console_read('h45, got);
		check_value("rdata", 128'(got), 128'(byte_a));
		console_read('h46, got);
		check_value("rdata", 128'(got), 128'(byte_b));
		// Neighbouring bytes of the same words are untouched
		console_read('h44, got);
		check_value("rdata", 128'(got), 128'(8'hFF));
		console_read('h47, got);
		check_value("rdata", 128'(got), 128'(8'hFF));
	endtask

	task automatic save_test();
		logic [15:0] bits;
		int          last_lba;
		// RAM size 1 is 2 KiB, four sectors
		last_lba = 3;
		img_mounted = 1'b1;
		img_readonly = 1'b0;
		img_size = 32'd0;
		cfg.sram_init = 2'd2;
		dl_begin(8'h00);
		dl_write(25'd0, 16'h001A);
		dl_write(25'd2, 16'h0000);
		repeat (3) next_cycle();
		dl_finish();
		check_value("bk_ena", 128'(bk_ena), 128'(1'b1));
		check_value("bk_pending", 128'(bk_pending), 128'(1'b0));
		check_value("bk_busy", 128'(bk_busy), 128'(1'b0));
		for (int i = 0; i < (last_lba + 1) * 512; i++) begin
			bits = take_bits(8);
			model[i] = bits[7:0];
			console_write(i, bits[7:0]);
		end
		check_value("bk_pending", 128'(bk_pending), 128'(1'b1));
		bk_save_req = 1'b1;
		next_cycle();
		bk_save_req = 1'b0;
		for (int lba = 0; lba <= last_lba; lba++) begin
			wait_request(1'b0);
			check_value("sd_lba", 128'(sd_lba), 128'(lba));
			serve_save_sector(lba);
		end
		wait_idle(1'b0);
		check_value("sd_lba", 128'(sd_lba), 128'(last_lba));
		check_value("bk_pending", 128'(bk_pending), 128'(1'b0));
	endtask

	task automatic load_test();
		logic [7:0] got;
		int         last_lba;
		// RAM size 1 is 2 KiB, four sectors
		last_lba = 3;
		img_size = 32'd2048;
		dl_begin(8'h00);
		dl_write(25'd0, 16'h001A);
		dl_write(25'd2, 16'h0000);
		dl_finish();
		for (int lba = 0; lba <= last_lba; lba++) begin
			wait_request(1'b1);
			check_value("sd_lba", 128'(sd_lba), 128'(lba));
			serve_load_sector(lba);
		end
		wait_idle(1'b1);
		img_size = 32'd0;
		for (int i = 0; i < (last_lba + 1) * 512; i++) begin
			console_read(i, got);
			check_value("rdata", 128'(got), 128'(model[i]));
		end
	endtask

	// ========================================
	// Sequence and watchdog
	// ========================================
	initial begin
		#(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
		fail_run("watchdog expired before the tests finished");
	end

	initial begin
		lfsr = 32'h90b3043d;
		RESET = 1'b1;
		dl = '0;
		cfg = '0;
		req = '0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		osd_status = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		check_value("sd_rd", 128'(sd_rd), 128'(1'b0));
		check_value("sd_wr", 128'(sd_wr), 128'(1'b0));
		check_value("bk_busy", 128'(bk_busy), 128'(1'b0));
		check_value("bk_loading", 128'(bk_loading), 128'(1'b0));
		check_value("bk_pending", 128'(bk_pending), 128'(1'b0));
		check_value("bk_ena", 128'(bk_ena), 128'(1'b0));
		check_value("code_valid", 128'(code_valid), 128'(1'b0));
		next_cycle();
		auto_header_test();
		forced_mode_test(3'd2, LOROM_SIZE_ADDR, 4'd9, 4'd5, 8'd0, 24'h07FFFF, 24'h007FFF);
		forced_mode_test(3'd3, HIROM_SIZE_ADDR, 4'd11, 4'd2, 8'd1, 24'h1FFFFF, 24'h000FFF);
		cheat_code_test();
		fill_console_test();
		save_test();
		load_test();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* tests/snes_cart_assertions.sv */
`timescale 1ns/100ps

module snes_cart_assertions (
	input logic clk_sys,
	input logic RESET,
	input logic sd_rd,
	input logic sd_wr,
	input logic code_valid,
	input logic bk_ena
);

	// Disk requests go one direction at a time
	no_dual_request: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr are high together");

	// One strobe per complete cheat code
	code_valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid held longer than one cycle");

	// Backup disabled means the disk stays idle
	request_needs_enable: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd_rd || sd_wr) |-> bk_ena)
		else $error("disk request while bk_ena is low");

endmodule

bind snes_cart_top snes_cart_assertions i_snes_cart_assertions (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.sd_rd      (sd_rd),
	.sd_wr      (sd_wr),
	.code_valid (code_valid),
	.bk_ena     (bk_ena)
);

/* hdl/snes_cart_top.sv */
`timescale 1ns/100ps

module snes_cart_top #(
	parameter int BSRAM_BITS = 17
) (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  snes_cart_pkg::dl_bus_t     dl,
	input  snes_cart_pkg::cart_cfg_t   cfg,
	input  snes_cart_pkg::bsram_req_t  req,
	output logic [7:0]                 rdata,
	output snes_cart_pkg::cart_info_t  cart_info,
	output snes_cart_pkg::cheat_code_t code,
	output logic                       code_valid,
	output logic [31:0]                sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	input  logic                       sd_ack,
	input  logic [7:0]                 sd_buff_addr,
	input  logic [15:0]                sd_buff_dout,
	input  logic                       sd_buff_wr,
	output logic [15:0]                sd_buff_din,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic [31:0]                img_size,
	input  logic                       osd_status,
	input  logic                       bk_load_req,
	input  logic                       bk_save_req,
	output logic                       bk_ena,
	output logic                       bk_pending,
	output logic                       bk_busy,
	output logic                       bk_loading
);

	// Console write seen by the BSRAM
	logic bsram_wr_pulse;

	rom_header_detect i_rom_header_detect (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl        (dl),
		.cfg       (cfg),
		.cart_info (cart_info)
	);

	cheat_code_loader i_cheat_code_loader (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl),
		.code       (code),
		.code_valid (code_valid)
	);

	bsram_access #(
		.BSRAM_BITS (BSRAM_BITS)
	) i_bsram_access (
		.clk_sys        (clk_sys),
		.dl             (dl),
		.sram_init      (cfg.sram_init),
		.req            (req),
		.rdata          (rdata),
		.bsram_wr_pulse (bsram_wr_pulse),
		.sd_lba         (sd_lba),
		.sd_buff_addr   (sd_buff_addr),
		.sd_buff_dout   (sd_buff_dout),
		.sd_buff_wr     (sd_buff_wr),
		.sd_ack         (sd_ack),
		.sd_buff_din    (sd_buff_din)
	);

	backup_sequencer #(
		.BSRAM_BITS (BSRAM_BITS)
	) i_backup_sequencer (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.dl             (dl),
		.ram_mask       (cart_info.ram_mask),
		.autosave       (cfg.autosave),
		.osd_status     (osd_status),
		.bk_load_req    (bk_load_req),
		.bk_save_req    (bk_save_req),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.bsram_wr_pulse (bsram_wr_pulse),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.sd_ack         (sd_ack),
		.bk_ena         (bk_ena),
		.bk_pending     (bk_pending),
		.bk_busy        (bk_busy),
		.bk_loading     (bk_loading)
	);

endmodule

/* hdl/backup_sequencer.sv */
`timescale 1ns/100ps

module backup_sequencer #(
	parameter int BSRAM_BITS = 17
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  snes_cart_pkg::dl_bus_t dl,
	input  logic [23:0]            ram_mask,
	input  logic                   autosave,
	input  logic                   osd_status,
	input  logic                   bk_load_req,
	input  logic                   bk_save_req,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic [31:0]            img_size,
	input  logic                   bsram_wr_pulse,
	output logic [31:0]            sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	input  logic                   sd_ack,
	output logic                   bk_ena,
	output logic                   bk_pending,
	output logic                   bk_busy,
	output logic                   bk_loading
);

	import snes_cart_pkg::*;

	// Last sector the BSRAM can hold
	localparam logic [31:0] MAX_LBA = 32'((2 ** (BSRAM_BITS - 9)) - 1);

	logic        cart_dl;
	logic        old_dl;
	logic        load_lvl;
	logic        save_lvl;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        load_edge;
	logic        save_edge;
	logic        dl_end;
	logic        start_load;
	logic [31:0] last_lba;

	assign cart_dl = is_cart_download(dl);

	assign load_lvl  = bk_load_req && bk_ena;
	assign save_lvl  = (bk_save_req || (bk_pending && osd_status && autosave)) && bk_ena;
	assign load_edge = load_lvl && !old_load;
	assign save_edge = save_lvl && !old_save;
	// Image is mounted by the time the download finishes
	assign dl_end     = old_dl && !cart_dl && (img_size != 32'd0) && bk_ena;
	assign start_load = load_edge || dl_end;

	// Sector count from the RAM mask, kept inside the buffer
	assign last_lba = (32'(ram_mask[23:9]) > MAX_LBA) ? MAX_LBA : 32'(ram_mask[23:9]);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_dl   <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_dl   <= cart_dl;
			old_load <= load_lvl;
			old_save <= save_lvl;
			old_ack  <= sd_ack;
		end
	end

	// ========================================
	// Enable and pending flags
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena <= 1'b0;
		end else begin
			if (cart_dl && !old_dl)
				bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			bk_pending <= 1'b0;
		else if (bk_ena && !osd_status && bsram_wr_pulse)
			bk_pending <= 1'b1;
		else if (bk_busy)
			bk_pending <= 1'b0;
	end

	// ========================================
	// Sector walk
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			// Host took the request
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (!bk_busy) begin
				if (start_load || save_edge) begin
					bk_busy    <= 1'b1;
					bk_loading <= start_load;
					sd_lba     <= '0;
					sd_rd      <= start_load;
					sd_wr      <= !start_load;
				end
			end else if (old_ack && !sd_ack) begin
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

endmodule

/* hdl/bsram_access.sv */
`timescale 1ns/100ps

module bsram_access #(
	parameter int BSRAM_BITS = 17
) (
	input  logic                      clk_sys,
	input  snes_cart_pkg::dl_bus_t    dl,
	input  logic [1:0]                sram_init,
	input  snes_cart_pkg::bsram_req_t req,
	output logic [7:0]                rdata,
	output logic                      bsram_wr_pulse,
	input  logic [31:0]               sd_lba,
	input  logic [7:0]                sd_buff_addr,
	input  logic [15:0]               sd_buff_dout,
	input  logic                      sd_buff_wr,
	input  logic                      sd_ack,
	output logic [15:0]               sd_buff_din
);

	import snes_cart_pkg::*;

	localparam int WORDS = 2 ** (BSRAM_BITS - 1);

	// Two byte lanes per word, lane 0 is the even byte
	logic [1:0][7:0] mem [WORDS];

	logic                  cart_dl;
	logic [BSRAM_BITS-1:0] a_addr;
	logic [7:0]            a_data;
	logic                  a_wr;
	logic [7:0]            fill_byte;
	logic [BSRAM_BITS-2:0] b_addr;
	logic                  b_wr;

	assign cart_dl = is_cart_download(dl);

	always_comb begin
		case (sram_init)
			2'd1:    fill_byte = 8'hFF;
			2'd2:    fill_byte = 8'h00;
			default: fill_byte = dl.addr[7:0];
		endcase
	end

	// ========================================
	// Port A, download fill has priority
	// ========================================
	assign a_addr = cart_dl ? dl.addr[BSRAM_BITS-1:0] : req.addr[BSRAM_BITS-1:0];
	assign a_data = cart_dl ? fill_byte : req.data;
	assign a_wr   = cart_dl ? dl.wr : (req.en && req.wr);

	assign bsram_wr_pulse = !cart_dl && req.en && req.wr;

	// Port B, one sector per LBA
	assign b_addr = {sd_lba[BSRAM_BITS-10:0], sd_buff_addr};
	assign b_wr   = sd_buff_wr && sd_ack;

	always_ff @(posedge clk_sys) begin
		if (a_wr)
			mem[a_addr[BSRAM_BITS-1:1]][a_addr[0]] <= a_data;
		if (b_wr)
			mem[b_addr] <= sd_buff_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (!cart_dl && req.en)
			rdata <= mem[a_addr[BSRAM_BITS-1:1]][a_addr[0]];
	end

	always_ff @(posedge clk_sys) begin
		sd_buff_din <= mem[b_addr];
	end

endmodule

/* hdl/cheat_code_loader.sv */
`timescale 1ns/100ps

module cheat_code_loader (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  snes_cart_pkg::dl_bus_t     dl,
	output snes_cart_pkg::cheat_code_t code,
	output logic                       code_valid
);

	import snes_cart_pkg::*;

	logic code_wr;

	assign code_wr = is_code_download(dl) && dl.wr;

	// Half-word assembly, low half of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:  code.flags[15:0]    <= dl.data;
				4'd2:  code.flags[31:16]   <= dl.data;
				4'd4:  code.address[15:0]  <= dl.data;
				4'd6:  code.address[31:16] <= dl.data;
				4'd8:  code.compare[15:0]  <= dl.data;
				4'd10: code.compare[31:16] <= dl.data;
				4'd12: code.replace[15:0]  <= dl.data;
				4'd14: code.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	// Offset 14 closes the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (dl.addr[3:0] == 4'd14);
	end

endmodule

/* hdl/rom_header_detect.sv */
`timescale 1ns/100ps

module rom_header_detect (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  snes_cart_pkg::dl_bus_t    dl,
	input  snes_cart_pkg::cart_cfg_t  cfg,
	output snes_cart_pkg::cart_info_t cart_info
);

	import snes_cart_pkg::*;

	logic        cart_dl;
	logic        forced_sizes;
	logic [24:0] size_addr;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic [7:0]  rom_type;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic        pal;

	assign cart_dl = is_cart_download(dl);

	// Location of the size word for the forced header modes
	always_comb begin
		forced_sizes = 1'b1;
		case (cfg.header_mode)
			3'd2: size_addr = LOROM_SIZE_ADDR + 25'(HDR_SKIP);
			3'd3: size_addr = HIROM_SIZE_ADDR + 25'(HDR_SKIP);
			3'd4: size_addr = EXHIROM_SIZE_ADDR + 25'(HDR_SKIP);
			default: begin
				size_addr    = '0;
				forced_sizes = 1'b0;
			end
		endcase
	end

	// ========================================
	// Header capture
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_region <= 1'b0;
			rom_type   <= '0;
			pal        <= 1'b0;
		end else if (cart_dl) begin
			if (dl.wr) begin
				if (dl.addr == 25'd0) begin
					rom_size <= 4'hC;
					ram_size <= 4'h0;
					// Auto mode: low byte packs RAM size over ROM size
					if (cfg.header_mode == 3'd0 && dl.data[7:0] != 8'd0)
						{ram_size, rom_size} <= dl.data[7:0];
					case (cfg.header_mode)
						3'd1, 3'd2: rom_type <= 8'd0;
						3'd3:       rom_type <= 8'd1;
						3'd4:       rom_type <= 8'd2;
						default:    rom_type <= dl.data[15:8];
					endcase
				end
				if (dl.addr == 25'd2)
					rom_region <= dl.data[8];
				if (forced_sizes) begin
					if (dl.addr == size_addr)
						rom_size <= dl.data[11:8];
					if (dl.addr == size_addr + 25'd2)
						ram_size <= dl.data[3:0];
				end
			end
		end else begin
			pal <= (cfg.region_sel == 2'd0) ? rom_region : cfg.region_sel[1];
		end
	end

	// Masks trail the size registers by a clock
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_mask <= '0;
			ram_mask <= '0;
		end else begin
			rom_mask <= (24'd1024 << rom_size) - 24'd1;
			ram_mask <= (ram_size != 4'd0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
		end
	end

	assign cart_info = '{rom_type: rom_type, rom_mask: rom_mask, ram_mask: ram_mask, pal: pal};

endmodule

/* hdl/snes_cart_pkg.sv */
package snes_cart_pkg;

	// ========================================
	// Download stream constants
	// ========================================

	// Index value reserved for cheat data
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// Copier header ahead of the ROM image
	localparam int HDR_SKIP = 512;

	// Header word holding the ROM size; RAM size sits two bytes later
	localparam logic [24:0] LOROM_SIZE_ADDR   = 25'h007FD6;
	localparam logic [24:0] HIROM_SIZE_ADDR   = 25'h00FFD6;
	localparam logic [24:0] EXHIROM_SIZE_ADDR = 25'h40FFD6;

	// ========================================
	// Shared structs
	// ========================================

	typedef struct packed {
		logic        active;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_bus_t;

	typedef struct packed {
		logic [2:0] header_mode;
		logic [1:0] region_sel;
		logic [1:0] sram_init;
		logic       autosave;
	} cart_cfg_t;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} cart_info_t;

	typedef struct packed {
		logic [19:0] addr;
		logic [7:0]  data;
		logic        en;
		logic        wr;
	} bsram_req_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Stream decode
	function automatic logic is_cart_download(dl_bus_t bus);
		return bus.active && (bus.index != CODE_INDEX);
	endfunction

	function automatic logic is_code_download(dl_bus_t bus);
		return bus.active && (bus.index == CODE_INDEX);
	endfunction

endpackage
